// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module core_tb -f verilog.f -o core_sim
	@out="$$(./obj_dir/core_sim)"; echo "$$out"; echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

// ==== bench/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    localparam int imem_depth = imem_depth_default;

    typedef struct packed {
        word_t first;
        word_t len;
        logic  probe_write;
        word_t probe_addr;
        logic  probe_slverr;
    } program_row_t;

    logic    aclk;
    logic    aresetn;
    logic    psel;
    logic    penable;
    logic    pwrite;
    word_t   paddr;
    word_t   pwdata;
    word_t   prdata;
    logic    pready;
    logic    pslverr;
    retire_t retire;

    word_t        prog_words [128];
    program_row_t programs [8];
    int           word_count = 0;
    int           prog_count = 0;
    word_t        model_imem [imem_depth];
    word_t        model_regs [16];
    retire_t      expected_retires [$];
    logic [31:0]  rand_state = 32'd47;

    int retire_errors = 0;
    int word_errors   = 0;
    int slverr_errors = 0;
    int other_errors  = 0;
    int cycle_count   = 0;
    int cycle_limit   = 1000;

    core_top #(.imem_depth(imem_depth)) core_top_inst (
        .aclk(aclk), .aresetn(aresetn),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .retire(retire)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, the run went past %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rand_state = xorshift(rand_state);
        return rand_state;
    endfunction

    task automatic check_retire(retire_t got, retire_t exp);
        logic bad;
        bad = (got.pc != exp.pc) || (got.we != exp.we);
        // rd and data only matter for instructions that write
        if (exp.we && ((got.rd != exp.rd) || (got.data != exp.data))) begin
            bad = 1'b1;
        end
        if (bad) begin
            retire_errors++;
            $display("error retire: got pc %h we %h rd %h data %h, exp pc %h we %h rd %h data %h",
                     got.pc, got.we, got.rd, got.data, exp.pc, exp.we, exp.rd, exp.data);
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got != exp) begin
            word_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_slverr(string what, logic got, logic exp);
        if (got != exp) begin
            slverr_errors++;
            $display("error pslverr on %s: got %h expected %h", what, got, exp);
        end
    endtask

    // trace is registered, stable at the falling edge
    always @(negedge aclk) begin
        if (retire.valid) begin
            if (expected_retires.size() == 0) begin
                other_errors++;
                $display("an instruction at pc %h retired when none was expected", retire.pc);
            end else begin
                check_retire(retire, expected_retires.pop_front());
            end
        end
    end

    // called at a falling edge, returns at one with the bus idle
    task automatic apb_write(word_t addr, word_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge aclk);
        penable = 1'b1;
        #2;
        while (!pready) begin
            @(negedge aclk);
            #2;
        end
        err = pslverr;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(word_t addr, output word_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge aclk);
        penable = 1'b1;
        #2;
        while (!pready) begin
            @(negedge aclk);
            #2;
        end
        data = prdata;
        err  = pslverr;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic begin_program(logic probe_write, word_t probe_addr, logic probe_slverr);
        programs[prog_count] = '{first: word_t'(word_count), len: '0,
                                 probe_write: probe_write, probe_addr: probe_addr,
                                 probe_slverr: probe_slverr};
        prog_count++;
    endtask

    task automatic emit_raw(word_t w);
        prog_words[word_count] = w;
        word_count++;
        programs[prog_count - 1].len = programs[prog_count - 1].len + 32'd1;
    endtask

    task automatic emit(op_e op, int rd, int rj, int rk, logic [15:0] imm);
        emit_raw({op, 4'(rd), 4'(rj), 4'(rk), imm});
    endtask

    task automatic build_programs();
        word_t r;
        word_t imm;
        op_e   op;
        int    i;
        // every register gets a known random value
        begin_program(1'b1, imem_base + 32'd400, 1'b1);
        for (i = 1; i < 16; i++) begin
            r = next_random();
            emit(addi, i, 0, 0, r[15:0]);
        end
        emit(halt, 0, 0, 0, 16'h0);
        // random alu ops, r0 and neighbor hazards show up by chance
        begin_program(1'b1, retired_addr, 1'b1);
        for (i = 0; i < 10; i++) begin
            r   = next_random();
            imm = next_random();
            op  = op_e'(4'd1 + 4'(r[31:16] % 16'd7));
            emit(op, int'(r[11:8]), int'(r[7:4]), int'(r[3:0]), imm[15:0]);
        end
        emit(halt, 0, 0, 0, 16'h0);
        // back to back read-after-write chain
        begin_program(1'b0, 32'h0000_0300, 1'b1);
        r = next_random();
        emit(addi, 1, 0, 0, r[15:0]);
        emit(add, 2, 1, 1, 16'h0);
        emit(sub, 3, 2, 1, 16'h0);
        emit(xor_op, 4, 3, 2, 16'h0);
        emit(addi, 5, 4, 0, r[31:16]);
        emit(or_op, 6, 5, 5, 16'h0);
        emit(and_op, 7, 6, 3, 16'h0);
        emit(halt, 0, 0, 0, 16'h0);
        // branches, taken and not taken
        begin_program(1'b1, reg_base + 32'd8, 1'b1);
        emit(addi, 1, 0, 0, 16'd5);
        emit(addi, 2, 0, 0, 16'd5);
        emit(beq, 0, 1, 2, 16'd2);
        emit(addi, 3, 0, 0, 16'h0111);
        emit(addi, 4, 0, 0, 16'h0222);
        emit(bne, 0, 1, 2, 16'd3);
        emit(addi, 5, 1, 0, 16'd1);
        emit(bne, 0, 5, 1, 16'd1);
        emit(addi, 6, 0, 0, 16'h0333);
        emit(beq, 0, 5, 1, 16'd2);
        r = next_random();
        emit(lui, 7, 0, 0, r[15:0]);
        emit(halt, 0, 0, 0, 16'h0);
        emit(addi, 8, 0, 0, 16'h0444);
        // r0 stays zero, unknown opcode runs as nop
        begin_program(1'b0, reg_base + 32'h40, 1'b1);
        r = next_random();
        emit(addi, 0, 0, 0, r[15:0]);
        emit(add, 0, 1, 2, 16'h0);
        emit(add, 8, 0, 0, 16'h0);
        emit_raw(32'hC123_4567);
        emit(lui, 0, 0, 0, r[31:16]);
        emit(or_op, 9, 0, 1, 16'h0);
        emit(halt, 0, 0, 0, 16'h0);
    endtask

    // instruction-level model of the loaded program
    task automatic run_model(output int retired_count);
        word_t   pc;
        word_t   next_pc;
        word_t   w;
        word_t   a;
        word_t   b;
        word_t   simm;
        word_t   res;
        op_e     op;
        logic    we;
        logic    done;
        retire_t exp;
        pc = '0;
        retired_count = 0;
        done = 1'b0;
        while (!done && retired_count < 200) begin
            w       = model_imem[pc % imem_depth];
            op      = (w[31:28] <= 4'd10) ? op_e'(w[31:28]) : nop;
            a       = model_regs[w[23:20]];
            b       = model_regs[w[19:16]];
            simm    = {{16{w[15]}}, w[15:0]};
            next_pc = pc + 32'd1;
            we      = 1'b1;
            res     = '0;
            case (op)
                add:    res = a + b;
                sub:    res = a - b;
                and_op: res = a & b;
                or_op:  res = a | b;
                xor_op: res = a ^ b;
                addi:   res = a + simm;
                lui:    res = {w[15:0], 16'h0000};
                beq: begin
                    we = 1'b0;
                    if (a == b) next_pc = pc + 32'd1 + simm;
                end
                bne: begin
                    we = 1'b0;
                    if (a != b) next_pc = pc + 32'd1 + simm;
                end
                halt: begin
                    we   = 1'b0;
                    done = 1'b1;
                end
                default: we = 1'b0;
            endcase
            exp = '{valid: 1'b1, pc: pc, we: we, rd: w[27:24], data: res};
            expected_retires.push_back(exp);
            if (we && w[27:24] != 4'd0) begin
                model_regs[w[27:24]] = res;
            end
            pc = next_pc;
            retired_count++;
        end
        if (!done) begin
            other_errors++;
            $display("model found no halt within 200 instructions");
        end
    endtask

    task automatic run_program(int p);
        program_row_t row;
        logic         err;
        word_t        data;
        int           count;
        int           i;
        row = programs[p];
        for (i = 0; i < int'(row.len); i++) begin
            apb_write(imem_base + word_t'(4 * i), prog_words[row.first + i], err);
            check_slverr("instruction load", err, 1'b0);
            model_imem[i] = prog_words[row.first + i];
        end
        run_model(count);
        apb_write(ctrl_addr, 32'd1, err);
        check_slverr("start", err, 1'b0);
        // host access while the core runs
        if (row.probe_write) begin
            apb_write(row.probe_addr, next_random(), err);
        end else begin
            apb_read(row.probe_addr, data, err);
        end
        check_slverr($sformatf("access to %h", row.probe_addr), err, row.probe_slverr);
        data = '0;
        while (!data[1]) begin
            apb_read(ctrl_addr, data, err);
        end
        check_word("ctrl", data, 32'd2);
        apb_read(retired_addr, data, err);
        check_word("retired", data, word_t'(count));
        if (expected_retires.size() != 0) begin
            other_errors++;
            $display("%0d instructions of program %0d never retired",
                     expected_retires.size(), p);
            expected_retires.delete();
        end
        for (i = 0; i < 16; i++) begin
            apb_read(reg_base + word_t'(4 * i), data, err);
            check_word($sformatf("r%0d", i), data, model_regs[i]);
            check_slverr("register read", err, 1'b0);
        end
    endtask

    initial begin
        logic  err;
        word_t data;
        int    p;
        aresetn = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (p = 0; p < 16; p++) begin
            model_regs[p] = '0;
        end
        build_programs();
        cycle_limit = 8 * word_count + 200;
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        apb_read(ctrl_addr, data, err);
        check_word("ctrl", data, 32'd0);
        check_slverr("ctrl read", err, 1'b0);
        apb_read(retired_addr, data, err);
        check_word("retired", data, 32'd0);
        for (p = 0; p < prog_count; p++) begin
            run_program(p);
        end
        @(negedge aclk);
        $display("errors: retire %0d, word %0d, pslverr %0d, other %0d",
                 retire_errors, word_errors, slverr_errors, other_errors);
        if (retire_errors + word_errors + slverr_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/apb_host_port.sv ====
`timescale 1ns/10ps

module apb_host_port #(
    parameter int imem_depth = core_pkg::imem_depth_default
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  core_pkg::word_t      paddr,
    input  core_pkg::word_t      pwdata,
    output core_pkg::word_t      prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 halt_retired,
    input  logic                 retire_valid,
    output logic                 run,
    output logic                 start,
    output core_pkg::imem_wr_t   imem_wr,
    output core_pkg::reg_idx_t   host_raddr,
    input  core_pkg::word_t      host_rdata
);
    import core_pkg::*;

    logic  access;
    logic  wr;
    logic  in_ctrl;
    logic  in_retired;
    logic  in_imem;
    logic  in_reg;
    word_t imem_off;
    word_t reg_off;
    logic  halted;
    word_t retired;

    assign access     = psel & penable;
    assign wr         = access & pwrite;
    assign imem_off   = paddr - imem_base;
    assign reg_off    = paddr - reg_base;
    assign in_ctrl    = (paddr == ctrl_addr);
    assign in_retired = (paddr == retired_addr);
    assign in_imem    = (paddr >= imem_base) && (imem_off < word_t'(imem_depth * 4));
    assign in_reg     = (paddr >= reg_base) && (reg_off < word_t'(reg_count * 4));

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access & ((pwrite & in_imem & run)
                             | (pwrite & (in_retired | in_reg))
                             | ~(in_ctrl | in_retired | in_imem | in_reg));

    assign start = wr & in_ctrl & pwdata[0];

    assign imem_wr.en   = wr & in_imem & ~run;
    assign imem_wr.addr = {2'b00, imem_off[31:2]};
    assign imem_wr.data = pwdata;

    assign host_raddr = reg_off[5:2];

    always_comb begin
        prdata = '0;
        if (in_ctrl) begin
            prdata = {30'd0, halted, run};
        end else if (in_retired) begin
            prdata = retired;
        end else if (in_reg) begin
            prdata = host_rdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            run     <= 1'b0;
            halted  <= 1'b0;
            retired <= '0;
        end else if (start) begin
            run     <= 1'b1;
            halted  <= 1'b0;
            retired <= '0;
        end else begin
            if (halt_retired) begin
                run    <= 1'b0;
                halted <= 1'b1;
            end
            if (retire_valid) begin
                retired <= retired + 32'd1;
            end
        end
    end

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    typedef enum logic [3:0] {
        nop    = 4'd0,
        add    = 4'd1,
        sub    = 4'd2,
        and_op = 4'd3,
        or_op  = 4'd4,
        xor_op = 4'd5,
        addi   = 4'd6,
        lui    = 4'd7,
        beq    = 4'd8,
        bne    = 4'd9,
        halt   = 4'd10
    } op_e;

    // one instruction word, msb first
    typedef struct packed {
        logic [3:0]  opcode;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        logic     valid;
        op_e      op;
        reg_idx_t rd;
        logic     we;
        word_t    operand_j;
        word_t    operand_k;
        word_t    imm;
        word_t    pc;
    } uop_t;

    typedef struct packed {
        logic     valid;
        logic     halt;
        logic     we;
        reg_idx_t rd;
        word_t    data;
        word_t    pc;
    } result_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef struct packed {
        logic  en;
        word_t addr;
        word_t data;
    } imem_wr_t;

    // apb byte addresses
    localparam word_t ctrl_addr    = 32'h0000_0000;
    localparam word_t retired_addr = 32'h0000_0004;
    localparam word_t imem_base    = 32'h0000_0400;
    localparam word_t reg_base     = 32'h0000_0800;

    localparam int reg_count          = 16;
    localparam int imem_depth_default = 256;

endpackage

// ==== hdl/core_top.sv ====
`timescale 1ns/10ps

module core_top #(
    parameter int imem_depth = core_pkg::imem_depth_default
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  core_pkg::word_t    paddr,
    input  core_pkg::word_t    pwdata,
    output core_pkg::word_t    prdata,
    output logic               pready,
    output logic               pslverr,
    output core_pkg::retire_t  retire
);
    import core_pkg::*;

    logic     run;
    logic     start;
    imem_wr_t imem_wr;
    reg_idx_t host_raddr;
    word_t    host_rdata;
    logic     if_valid;
    word_t    if_pc;
    word_t    if_instr;
    reg_idx_t raddr_j;
    reg_idx_t raddr_k;
    word_t    rdata_j;
    word_t    rdata_k;
    logic     stall;
    uop_t     uop;
    result_t  result;
    logic     redirect_en;
    word_t    redirect_pc;
    logic     wen;
    reg_idx_t waddr;
    word_t    wdata;
    logic     halt_retired;
    logic     flush_front;
    logic     flush_back;

    // a taken branch kills only what is behind it
    assign flush_front = redirect_en | halt_retired | start;
    assign flush_back  = halt_retired | start;

    apb_host_port #(.imem_depth(imem_depth)) apb_host_port_inst (
        .aclk(aclk), .aresetn(aresetn),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .halt_retired(halt_retired), .retire_valid(retire.valid),
        .run(run), .start(start), .imem_wr(imem_wr),
        .host_raddr(host_raddr), .host_rdata(host_rdata)
    );

    fetch_unit #(.imem_depth(imem_depth)) fetch_unit_inst (
        .aclk(aclk), .aresetn(aresetn),
        .run(run), .start(start), .flush(flush_front), .stall(stall),
        .redirect_en(redirect_en), .redirect_pc(redirect_pc), .imem_wr(imem_wr),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr)
    );

    decode_stage decode_stage_inst (
        .aclk(aclk), .aresetn(aresetn), .flush(flush_front),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr),
        .rdata_j(rdata_j), .rdata_k(rdata_k),
        .raddr_j(raddr_j), .raddr_k(raddr_k),
        .stall(stall), .uop(uop)
    );

    execute_stage execute_stage_inst (
        .aclk(aclk), .aresetn(aresetn), .flush(flush_back), .uop(uop),
        .result(result), .redirect_en(redirect_en), .redirect_pc(redirect_pc)
    );

    register_file register_file_inst (
        .aclk(aclk),
        .raddr_j(raddr_j), .raddr_k(raddr_k), .host_raddr(host_raddr),
        .wen(wen), .waddr(waddr), .wdata(wdata),
        .rdata_j(rdata_j), .rdata_k(rdata_k), .host_rdata(host_rdata)
    );

    writeback_stage writeback_stage_inst (
        .aclk(aclk), .aresetn(aresetn), .result(result),
        .wen(wen), .waddr(waddr), .wdata(wdata),
        .halt_retired(halt_retired), .retire(retire)
    );

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                flush,
    input  logic                if_valid,
    input  core_pkg::word_t     if_pc,
    input  core_pkg::word_t     if_instr,
    input  core_pkg::word_t     rdata_j,
    input  core_pkg::word_t     rdata_k,
    output core_pkg::reg_idx_t  raddr_j,
    output core_pkg::reg_idx_t  raddr_k,
    output logic                stall,
    output core_pkg::uop_t      uop
);
    import core_pkg::*;

    instr_t f;
    op_e    op;
    logic   uses_j;
    logic   uses_k;
    logic   we;
    uop_t   uop_next;

    assign f       = if_instr;
    assign raddr_j = f.rj;
    assign raddr_k = f.rk;

    // unknown opcodes run as nop
    always_comb begin
        if (f.opcode <= halt) begin
            op = op_e'(f.opcode);
        end else begin
            op = nop;
        end
    end

    always_comb begin
        uses_j = 1'b0;
        uses_k = 1'b0;
        we     = 1'b0;
        case (op)
            add, sub, and_op, or_op, xor_op: begin
                uses_j = 1'b1;
                uses_k = 1'b1;
                we     = 1'b1;
            end
            addi: begin
                uses_j = 1'b1;
                we     = 1'b1;
            end
            lui: we = 1'b1;
            beq, bne: begin
                uses_j = 1'b1;
                uses_k = 1'b1;
            end
            default: ;
        endcase
    end

    // result still in execute, wait one cycle for the bypass
    assign stall = if_valid & uop.valid & uop.we
                 & ((uses_j & (f.rj == uop.rd)) | (uses_k & (f.rk == uop.rd)));

    always_comb begin
        uop_next.valid     = if_valid & ~stall & ~flush;
        uop_next.op        = op;
        uop_next.rd        = f.rd;
        uop_next.we        = we;
        uop_next.operand_j = rdata_j;
        uop_next.operand_k = rdata_k;
        uop_next.imm       = (op == lui) ? {f.imm, 16'h0000} : {{16{f.imm[15]}}, f.imm};
        uop_next.pc        = if_pc;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            uop.valid <= 1'b0;
        end else begin
            uop <= uop_next;
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                flush,
    input  core_pkg::uop_t      uop,
    output core_pkg::result_t   result,
    output logic                redirect_en,
    output core_pkg::word_t     redirect_pc
);
    import core_pkg::*;

    word_t alu;
    logic  equal;

    assign equal = (uop.operand_j == uop.operand_k);

    always_comb begin
        case (uop.op)
            add:     alu = uop.operand_j + uop.operand_k;
            sub:     alu = uop.operand_j - uop.operand_k;
            and_op:  alu = uop.operand_j & uop.operand_k;
            or_op:   alu = uop.operand_j | uop.operand_k;
            xor_op:  alu = uop.operand_j ^ uop.operand_k;
            addi:    alu = uop.operand_j + uop.imm;
            lui:     alu = uop.imm;
            default: alu = '0;
        endcase
    end

    // branch target is relative to the next word
    assign redirect_en = uop.valid
                       & (((uop.op == beq) & equal) | ((uop.op == bne) & ~equal));
    assign redirect_pc = uop.pc + 32'd1 + uop.imm;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= uop.valid & ~flush;
            result.halt  <= (uop.op == halt);
            result.we    <= uop.we;
            result.rd    <= uop.rd;
            result.data  <= alu;
            result.pc    <= uop.pc;
        end
    end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit #(
    parameter int imem_depth = core_pkg::imem_depth_default
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                run,
    input  logic                start,
    input  logic                flush,
    input  logic                stall,
    input  logic                redirect_en,
    input  core_pkg::word_t     redirect_pc,
    input  core_pkg::imem_wr_t  imem_wr,
    output logic                if_valid,
    output core_pkg::word_t     if_pc,
    output core_pkg::word_t     if_instr
);
    import core_pkg::*;

    localparam int idx_w = $clog2(imem_depth);

    word_t imem [imem_depth];
    word_t pc;

    always_ff @(posedge aclk) begin
        if (imem_wr.en) begin
            imem[imem_wr.addr[idx_w-1:0]] <= imem_wr.data;
        end
    end

    // fall-through unless redirected
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else begin
            if (start) begin
                pc <= '0;
            end else if (redirect_en) begin
                pc <= redirect_pc;
            end else if (run && !stall) begin
                pc <= pc + 32'd1;
            end
            if (flush) begin
                if_valid <= 1'b0;
            end else if (!stall) begin
                if_valid <= run;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!stall) begin
            if_instr <= imem[pc[idx_w-1:0]];
            if_pc    <= pc;
        end
    end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic                aclk,
    input  core_pkg::reg_idx_t  raddr_j,
    input  core_pkg::reg_idx_t  raddr_k,
    input  core_pkg::reg_idx_t  host_raddr,
    input  logic                wen,
    input  core_pkg::reg_idx_t  waddr,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata_j,
    output core_pkg::word_t     rdata_k,
    output core_pkg::word_t     host_rdata
);
    import core_pkg::*;

    word_t regs [reg_count];

    // r0 reads zero and a same-cycle write wins
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wen && waddr == idx) begin
            return wdata;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge aclk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata_j    = read_port(raddr_j);
        rdata_k    = read_port(raddr_k);
        host_rdata = read_port(host_raddr);
    end

endmodule

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage (
    input  logic                aclk,
    input  logic                aresetn,
    input  core_pkg::result_t   result,
    output logic                wen,
    output core_pkg::reg_idx_t  waddr,
    output core_pkg::word_t     wdata,
    output logic                halt_retired,
    output core_pkg::retire_t   retire
);
    import core_pkg::*;

    assign wen          = result.valid & result.we;
    assign waddr        = result.rd;
    assign wdata        = result.data;
    assign halt_retired = result.valid & result.halt;

    // trace lags the register write by one cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= result.valid;
            retire.pc    <= result.pc;
            retire.we    <= result.we;
            retire.rd    <= result.rd;
            retire.data  <= result.data;
        end
    end

endmodule

// ==== verilog.f ====
hdl/core_pkg.sv
hdl/register_file.sv
hdl/apb_host_port.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
bench/core_tb.sv
